/* rtl/ext_bus_pkg.sv */
// ####################
// Sizes, bus and register structs, DMA enums
// ####################
package ext_bus_pkg;

  localparam int unsigned ADDR_W             = 32;
  localparam int unsigned DATA_W             = 32;
  localparam int unsigned BE_W               = 4;
  localparam int unsigned MEM_WORDS          = 128;
  localparam int unsigned MEM_IDX_W          = 7;
  localparam int unsigned MEM_WAIT_CYCLES    = 3;
  localparam int unsigned MEM_WAIT_W         = $clog2(MEM_WAIT_CYCLES + 1);
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned NUM_DOMAINS        = 4;
  localparam int unsigned NUM_MASTERS        = 2;
  localparam int unsigned MST_IDX_W          = $clog2(NUM_MASTERS);
  localparam int unsigned REG_ADDR_W         = 5;

  localparam int unsigned HOST_IDX = 0;
  localparam int unsigned DMA_IDX  = 1;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Single-cycle register strobe
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } reg_req_t;

  typedef enum logic [REG_ADDR_W-1:0] {
    REG_SRC    = 5'h00,
    REG_DST    = 5'h04,
    REG_LEN    = 5'h08,
    REG_CTRL   = 5'h0C,
    REG_STATUS = 5'h10
  } dma_reg_e;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_WRITE,
    DMA_DONE
  } dma_state_e;

endpackage

/* rtl/slow_memory.sv */
// ####################
// Slow word memory with fixed grant wait states
// ####################
`timescale 1ns/1ps

module slow_memory (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ext_bus_pkg::bus_req_t req_i,
  output ext_bus_pkg::bus_rsp_t rsp_o
);

  logic [ext_bus_pkg::DATA_W-1:0]     mem_q [ext_bus_pkg::MEM_WORDS];
  logic [ext_bus_pkg::MEM_WAIT_W-1:0] wait_q;
  logic [ext_bus_pkg::MEM_IDX_W-1:0]  idx;
  logic [ext_bus_pkg::DATA_W-1:0]     rdata_q;
  logic                               rvalid_q;
  logic                               gnt;

  assign idx = req_i.addr[ext_bus_pkg::MEM_IDX_W+1:2];
  assign gnt = req_i.req &&
               (wait_q == ext_bus_pkg::MEM_WAIT_W'(ext_bus_pkg::MEM_WAIT_CYCLES));

  // Wait states count while the request is held
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      if (!req_i.req || gnt) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      if (req_i.we) begin
        for (int b = 0; b < ext_bus_pkg::BE_W; b++) begin
          if (req_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rsp_o.gnt    = gnt;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

/* rtl/bus_arbiter.sv */
// ####################
// Round-robin arbiter, host and DMA onto memory
// ####################
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  ext_bus_pkg::bus_req_t [ext_bus_pkg::NUM_MASTERS-1:0] mst_req_i,
  output ext_bus_pkg::bus_rsp_t [ext_bus_pkg::NUM_MASTERS-1:0] mst_rsp_o,
  output ext_bus_pkg::bus_req_t                                slv_req_o,
  input  ext_bus_pkg::bus_rsp_t                                slv_rsp_i
);

  logic [ext_bus_pkg::MST_IDX_W-1:0] last_q;
  logic [ext_bus_pkg::MST_IDX_W-1:0] sel_q;
  logic [ext_bus_pkg::MST_IDX_W-1:0] owner_q;
  logic [ext_bus_pkg::MST_IDX_W-1:0] pick;
  logic [ext_bus_pkg::MST_IDX_W-1:0] sel;
  logic                              locked_q;
  logic                              any_req;

  // Nearest requester after the last one served wins
  always_comb begin
    int unsigned cand;
    pick    = last_q;
    any_req = 1'b0;
    for (int k = ext_bus_pkg::NUM_MASTERS; k >= 1; k--) begin
      cand = (int'(last_q) + k) % ext_bus_pkg::NUM_MASTERS;
      if (mst_req_i[cand].req) begin
        pick    = ext_bus_pkg::MST_IDX_W'(cand);
        any_req = 1'b1;
      end
    end
  end

  assign sel       = locked_q ? sel_q : pick;
  assign slv_req_o = mst_req_i[sel];

  for (genvar i = 0; i < ext_bus_pkg::NUM_MASTERS; i++) begin : gen_rsp
    logic is_owner;
    assign is_owner = (owner_q == ext_bus_pkg::MST_IDX_W'(i));
    assign mst_rsp_o[i].gnt    = slv_rsp_i.gnt && (sel == ext_bus_pkg::MST_IDX_W'(i));
    assign mst_rsp_o[i].rvalid = slv_rsp_i.rvalid && is_owner;
    assign mst_rsp_o[i].rdata  = (slv_rsp_i.rvalid && is_owner) ? slv_rsp_i.rdata : '0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      locked_q <= 1'b0;
      sel_q    <= '0;
      owner_q  <= '0;
      // Host goes first when both start together
      last_q   <= ext_bus_pkg::MST_IDX_W'(ext_bus_pkg::DMA_IDX);
    end else if (slv_rsp_i.gnt) begin
      locked_q <= 1'b0;
      last_q   <= sel;
      owner_q  <= sel;
    end else if (!locked_q && any_req) begin
      locked_q <= 1'b1;
      sel_q    <= pick;
    end
  end

endmodule

/* rtl/memcopy_dma.sv */
// ####################
// Memcopy DMA, register block and copy FSM
// ####################
`timescale 1ns/1ps

module memcopy_dma (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  ext_bus_pkg::reg_req_t          reg_req_i,
  output logic [ext_bus_pkg::DATA_W-1:0] reg_rdata_o,
  output ext_bus_pkg::bus_req_t          bus_req_o,
  input  ext_bus_pkg::bus_rsp_t          bus_rsp_i,
  output logic                           dma_done_intr_o
);

  ext_bus_pkg::dma_state_e        state_q;
  ext_bus_pkg::dma_reg_e          reg_sel;
  logic [ext_bus_pkg::ADDR_W-1:0] src_q;
  logic [ext_bus_pkg::ADDR_W-1:0] dst_q;
  logic [ext_bus_pkg::DATA_W-1:0] len_q;
  logic [ext_bus_pkg::DATA_W-1:0] remain_q;
  logic [ext_bus_pkg::DATA_W-1:0] buf_q;
  logic                           wait_q;
  logic                           busy;
  logic                           reg_wr;
  logic                           start;

  assign reg_sel = ext_bus_pkg::dma_reg_e'(reg_req_i.addr);
  assign reg_wr  = reg_req_i.valid && reg_req_i.write;
  assign busy    = (state_q == ext_bus_pkg::DMA_READ) || (state_q == ext_bus_pkg::DMA_WRITE);
  assign start   = reg_wr && (reg_sel == ext_bus_pkg::REG_CTRL) && !busy;

  assign dma_done_intr_o = (state_q == ext_bus_pkg::DMA_DONE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= ext_bus_pkg::DMA_IDLE;
      src_q    <= '0;
      dst_q    <= '0;
      len_q    <= '0;
      remain_q <= '0;
      wait_q   <= 1'b0;
    end else begin
      // Configuration is frozen during a copy
      if (reg_wr && !busy) begin
        case (reg_sel)
          ext_bus_pkg::REG_SRC: src_q <= reg_req_i.wdata;
          ext_bus_pkg::REG_DST: dst_q <= reg_req_i.wdata;
          ext_bus_pkg::REG_LEN: len_q <= reg_req_i.wdata;
          default: ;
        endcase
      end
      case (state_q)
        ext_bus_pkg::DMA_IDLE, ext_bus_pkg::DMA_DONE: begin
          state_q <= ext_bus_pkg::DMA_IDLE;
          if (start) begin
            remain_q <= len_q;
            state_q  <= (len_q == '0) ? ext_bus_pkg::DMA_DONE : ext_bus_pkg::DMA_READ;
          end
        end
        ext_bus_pkg::DMA_READ: begin
          if (bus_rsp_i.gnt) begin
            wait_q <= 1'b1;
          end
          if (bus_rsp_i.rvalid) begin
            wait_q  <= 1'b0;
            src_q   <= src_q + 4;
            state_q <= ext_bus_pkg::DMA_WRITE;
          end
        end
        ext_bus_pkg::DMA_WRITE: begin
          if (bus_rsp_i.gnt) begin
            wait_q <= 1'b1;
          end
          if (bus_rsp_i.rvalid) begin
            wait_q   <= 1'b0;
            dst_q    <= dst_q + 4;
            remain_q <= remain_q - 1'b1;
            // Last word written
            state_q  <= (remain_q == 1) ? ext_bus_pkg::DMA_DONE : ext_bus_pkg::DMA_READ;
          end
        end
        default: state_q <= ext_bus_pkg::DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ext_bus_pkg::DMA_READ) && bus_rsp_i.rvalid) begin
      buf_q <= bus_rsp_i.rdata;
    end
  end

  // Request drops after gnt until rvalid
  always_comb begin
    bus_req_o       = '0;
    bus_req_o.req   = busy && !wait_q;
    bus_req_o.we    = (state_q == ext_bus_pkg::DMA_WRITE);
    bus_req_o.be    = '1;
    bus_req_o.addr  = (state_q == ext_bus_pkg::DMA_WRITE) ? dst_q : src_q;
    bus_req_o.wdata = buf_q;
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_sel)
      ext_bus_pkg::REG_SRC:    reg_rdata_o = src_q;
      ext_bus_pkg::REG_DST:    reg_rdata_o = dst_q;
      ext_bus_pkg::REG_LEN:    reg_rdata_o = len_q;
      ext_bus_pkg::REG_STATUS: reg_rdata_o = {{(ext_bus_pkg::DATA_W-1){1'b0}}, busy};
      default: ;
    endcase
  end

endmodule

/* rtl/powergate_ack_delay.sv */
// ####################
// Switch cell acknowledge delay line
// ####################
`timescale 1ns/1ps

module powergate_ack_delay (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [ext_bus_pkg::NUM_DOMAINS-1:0] switch_no,
  output logic [ext_bus_pkg::NUM_DOMAINS-1:0] switch_ack_no
);

  logic [ext_bus_pkg::NUM_DOMAINS-1:0] stage_q [ext_bus_pkg::SWITCH_ACK_LATENCY];

  // Active low, so ones mean switched off
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < ext_bus_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_no;
      for (int i = 1; i < ext_bus_pkg::SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_no = stage_q[ext_bus_pkg::SWITCH_ACK_LATENCY-1];

endmodule

/* rtl/ext_subsystem.sv */
// ####################
// External subsystem top
// ####################
`timescale 1ns/1ps

module ext_subsystem (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  ext_bus_pkg::bus_req_t               host_req_i,
  output ext_bus_pkg::bus_rsp_t               host_rsp_o,
  input  ext_bus_pkg::reg_req_t               reg_req_i,
  output logic [ext_bus_pkg::DATA_W-1:0]      reg_rdata_o,
  output logic                                dma_done_intr_o,
  input  logic [ext_bus_pkg::NUM_DOMAINS-1:0] switch_no,
  output logic [ext_bus_pkg::NUM_DOMAINS-1:0] switch_ack_no
);

  ext_bus_pkg::bus_req_t [ext_bus_pkg::NUM_MASTERS-1:0] mst_req;
  ext_bus_pkg::bus_rsp_t [ext_bus_pkg::NUM_MASTERS-1:0] mst_rsp;
  ext_bus_pkg::bus_req_t                                mem_req;
  ext_bus_pkg::bus_rsp_t                                mem_rsp;

  assign mst_req[ext_bus_pkg::HOST_IDX] = host_req_i;
  assign host_rsp_o = mst_rsp[ext_bus_pkg::HOST_IDX];

  memcopy_dma dma_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .reg_req_i       (reg_req_i),
    .reg_rdata_o     (reg_rdata_o),
    .bus_req_o       (mst_req[ext_bus_pkg::DMA_IDX]),
    .bus_rsp_i       (mst_rsp[ext_bus_pkg::DMA_IDX]),
    .dma_done_intr_o (dma_done_intr_o)
  );

  bus_arbiter arbiter_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .mst_req_i (mst_req),
    .mst_rsp_o (mst_rsp),
    .slv_req_o (mem_req),
    .slv_rsp_i (mem_rsp)
  );

  slow_memory slow_ram_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  powergate_ack_delay switch_delay_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .switch_no     (switch_no),
    .switch_ack_no (switch_ack_no)
  );

endmodule

/* tests/ext_subsystem_sva.sv */
// ####################
// Bound checks on bus handshakes and the DMA interrupt
// ####################
`timescale 1ns/1ps

module ext_subsystem_sva (
  input logic                                                 clk_i,
  input logic                                                 rst_i,
  input ext_bus_pkg::bus_rsp_t                                host_rsp_i,
  input ext_bus_pkg::bus_req_t [ext_bus_pkg::NUM_MASTERS-1:0] mst_req_i,
  input ext_bus_pkg::bus_rsp_t [ext_bus_pkg::NUM_MASTERS-1:0] mst_rsp_i,
  input logic                                                 dma_done_intr_i
);

  host_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    host_rsp_i.gnt |=> host_rsp_i.rvalid)
    else $error("host rvalid missing one cycle after gnt");

  host_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    host_rsp_i.rvalid |-> $past(host_rsp_i.gnt))
    else $error("host rvalid without a gnt one cycle before");

  intr_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    dma_done_intr_i |=> !dma_done_intr_i)
    else $error("done interrupt longer than one cycle");

  for (genvar i = 0; i < ext_bus_pkg::NUM_MASTERS; i++) begin : gen_stable
    // Waiting request keeps all fields
    req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (mst_req_i[i].req && !mst_rsp_i[i].gnt) |=>
        (mst_req_i[i].req && $stable(mst_req_i[i].we) && $stable(mst_req_i[i].be) &&
         $stable(mst_req_i[i].addr) && $stable(mst_req_i[i].wdata)))
      else $error("request changed before gnt");

    // Grant only to the master that asks
    gnt_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
      mst_rsp_i[i].gnt |-> mst_req_i[i].req)
      else $error("gnt given to a master without a request");
  end

endmodule

bind ext_subsystem ext_subsystem_sva sva_i (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .host_rsp_i      (host_rsp_o),
  .mst_req_i       (mst_req),
  .mst_rsp_i       (mst_rsp),
  .dma_done_intr_i (dma_done_intr_o)
);

/* tests/tb_ext_subsystem.sv */
// ####################
// Testbench for the external subsystem
// Stimulus table, shadow memory, watchdog
// ####################
`timescale 1ns/1ps

module tb_ext_subsystem;

  localparam int CLK_PERIOD   = 8;
  localparam int NUM_ENTRIES  = 15;
  localparam int MAX_LEN      = 4;
  localparam int ENTRY_CYCLES = 4 * (MAX_LEN + 2) * ext_bus_pkg::MEM_WAIT_CYCLES +
                                ext_bus_pkg::SWITCH_ACK_LATENCY + 20;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * ENTRY_CYCLES;

  typedef enum logic [2:0] {
    OP_HOST_WRITE,
    OP_HOST_READ,
    OP_DMA_COPY,
    OP_READ_DURING_COPY,
    OP_SWITCH
  } tb_op_e;

  typedef struct packed {
    tb_op_e                              op;
    logic [ext_bus_pkg::ADDR_W-1:0]      addr;
    logic [ext_bus_pkg::DATA_W-1:0]      wdata;
    logic [ext_bus_pkg::BE_W-1:0]        be;
    logic [ext_bus_pkg::ADDR_W-1:0]      src;
    logic [ext_bus_pkg::ADDR_W-1:0]      dst;
    logic [ext_bus_pkg::DATA_W-1:0]      len;
    logic [ext_bus_pkg::NUM_DOMAINS-1:0] switch_val;
  } stim_entry_t;

  logic                                clk_i;
  logic                                rst_i;
  ext_bus_pkg::bus_req_t               host_req_i;
  ext_bus_pkg::bus_rsp_t               host_rsp_o;
  ext_bus_pkg::reg_req_t               reg_req_i;
  logic [ext_bus_pkg::DATA_W-1:0]      reg_rdata_o;
  logic                                dma_done_intr_o;
  logic [ext_bus_pkg::NUM_DOMAINS-1:0] switch_no;
  logic [ext_bus_pkg::NUM_DOMAINS-1:0] switch_ack_no;

  stim_entry_t                    stim_q [NUM_ENTRIES];
  logic [ext_bus_pkg::DATA_W-1:0] shadow_q [ext_bus_pkg::MEM_WORDS];
  logic [31:0]                    lcg_state;
  int                             errors = 0;
  int                             checks = 0;
  int                             intr_count = 0;

  ext_subsystem uut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .host_req_i      (host_req_i),
    .host_rsp_o      (host_rsp_o),
    .reg_req_i       (reg_req_i),
    .reg_rdata_o     (reg_rdata_o),
    .dma_done_intr_o (dma_done_intr_o),
    .switch_no       (switch_no),
    .switch_ack_no   (switch_ack_no)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Interrupt cycles seen, read only at rising edges
  always @(negedge clk_i) begin
    if (!rst_i && dma_done_intr_o) begin
      intr_count++;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [ext_bus_pkg::MEM_IDX_W-1:0] word_idx(input logic [31:0] addr);
    return addr[ext_bus_pkg::MEM_IDX_W+1:2];
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic stim_entry_t make_entry(input tb_op_e op, input logic [31:0] addr,
                                             input logic [3:0] be, input logic [31:0] src,
                                             input logic [31:0] dst, input logic [31:0] len,
                                             input logic [3:0] sw);
    stim_entry_t e;
    e.op         = op;
    e.addr       = addr;
    e.wdata      = lcg_next();
    e.be         = be;
    e.src        = src;
    e.dst        = dst;
    e.len        = len;
    e.switch_val = sw;
    return e;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %0t: %s, got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  // Request held through the rising edge that takes the grant
  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             output logic [31:0] rdata);
    @(negedge clk_i);
    host_req_i.req   = 1'b1;
    host_req_i.we    = we;
    host_req_i.be    = be;
    host_req_i.addr  = addr;
    host_req_i.wdata = wdata;
    do @(negedge clk_i); while (!host_rsp_o.gnt);
    @(negedge clk_i);
    host_req_i = '0;
    check_value("host rvalid one cycle after gnt", 32'(host_rsp_o.rvalid), 32'd1);
    rdata = host_rsp_o.rdata;
  endtask

  task automatic reg_write(input ext_bus_pkg::dma_reg_e offset, input logic [31:0] data);
    @(negedge clk_i);
    reg_req_i.valid = 1'b1;
    reg_req_i.write = 1'b1;
    reg_req_i.addr  = offset;
    reg_req_i.wdata = data;
    @(negedge clk_i);
    reg_req_i = '0;
  endtask

  task automatic reg_read(input ext_bus_pkg::dma_reg_e offset, output logic [31:0] data);
    @(negedge clk_i);
    reg_req_i.valid = 1'b1;
    reg_req_i.write = 1'b0;
    reg_req_i.addr  = offset;
    #(CLK_PERIOD / 4);
    data = reg_rdata_o;
    @(negedge clk_i);
    reg_req_i = '0;
  endtask

  task automatic host_read_check(input string what, input logic [31:0] addr);
    logic [31:0] rd;
    host_access(1'b0, addr, 32'h0, 4'h0, rd);
    check_value(what, rd, shadow_q[word_idx(addr)]);
  endtask

  task automatic run_copy(input stim_entry_t e, input logic read_during);
    int          count0;
    logic [31:0] status;
    @(posedge clk_i);
    count0 = intr_count;
    reg_write(ext_bus_pkg::REG_SRC, e.src);
    reg_write(ext_bus_pkg::REG_DST, e.dst);
    reg_write(ext_bus_pkg::REG_LEN, e.len);
    reg_write(ext_bus_pkg::REG_CTRL, 32'h1);
    if (e.len != 0) begin
      reg_read(ext_bus_pkg::REG_STATUS, status);
      check_value("busy during copy", status, 32'h1);
      // Second start while busy must be dropped
      reg_write(ext_bus_pkg::REG_CTRL, 32'h1);
    end
    if (read_during) begin
      host_read_check("host read during copy", e.addr);
    end
    do @(posedge clk_i); while (intr_count == count0);
    repeat (4) @(posedge clk_i);
    check_value("done interrupt cycles", 32'(intr_count - count0), 32'd1);
    reg_read(ext_bus_pkg::REG_STATUS, status);
    check_value("status after copy", status, 32'h0);
    for (int i = 0; i < int'(e.len); i++) begin
      shadow_q[word_idx(e.dst) + i] = shadow_q[word_idx(e.src) + i];
    end
    for (int i = 0; i < int'(e.len); i++) begin
      host_read_check("copied word", e.dst + 32'(4 * i));
    end
    if (e.len == 0) begin
      host_read_check("word untouched by empty copy", e.dst);
    end
  endtask

  task automatic run_switch(input logic [3:0] val);
    logic [3:0] old_val;
    old_val = switch_no;
    @(negedge clk_i);
    switch_no = val;
    for (int k = 1; k < ext_bus_pkg::SWITCH_ACK_LATENCY; k++) begin
      @(negedge clk_i);
      check_value("switch ack before latency", 32'(switch_ack_no), 32'(old_val));
    end
    @(negedge clk_i);
    check_value("switch ack at latency", 32'(switch_ack_no), 32'(val));
  endtask

  task automatic apply_entry(input stim_entry_t e);
    logic [31:0] rd;
    case (e.op)
      OP_HOST_WRITE: begin
        host_access(1'b1, e.addr, e.wdata, e.be, rd);
        shadow_q[word_idx(e.addr)] = merge_bytes(shadow_q[word_idx(e.addr)], e.wdata, e.be);
      end
      OP_HOST_READ:        host_read_check("host read", e.addr);
      OP_DMA_COPY:         run_copy(e, 1'b0);
      OP_READ_DURING_COPY: run_copy(e, 1'b1);
      default:             run_switch(e.switch_val);
    endcase
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    logic [31:0] status;
    clk_i      = 1'b0;
    rst_i      = 1'b1;
    host_req_i = '0;
    reg_req_i  = '0;
    switch_no  = '1;
    lcg_state  = 32'hb7e4;
    stim_q[0]  = make_entry(OP_HOST_WRITE, 32'h000, 4'hF, 0, 0, 0, 4'h0);
    stim_q[1]  = make_entry(OP_HOST_WRITE, 32'h004, 4'hF, 0, 0, 0, 4'h0);
    stim_q[2]  = make_entry(OP_HOST_WRITE, 32'h008, 4'hF, 0, 0, 0, 4'h0);
    stim_q[3]  = make_entry(OP_HOST_WRITE, 32'h00C, 4'hF, 0, 0, 0, 4'h0);
    stim_q[4]  = make_entry(OP_HOST_WRITE, 32'h004, 4'h5, 0, 0, 0, 4'h0);
    stim_q[5]  = make_entry(OP_HOST_WRITE, 32'h00C, 4'h8, 0, 0, 0, 4'h0);
    stim_q[6]  = make_entry(OP_HOST_READ, 32'h004, 4'h0, 0, 0, 0, 4'h0);
    stim_q[7]  = make_entry(OP_HOST_READ, 32'h00C, 4'h0, 0, 0, 0, 4'h0);
    stim_q[8]  = make_entry(OP_DMA_COPY, 32'h0, 4'h0, 32'h000, 32'h100, 4, 4'h0);
    stim_q[9]  = make_entry(OP_HOST_WRITE, 32'h040, 4'hF, 0, 0, 0, 4'h0);
    stim_q[10] = make_entry(OP_READ_DURING_COPY, 32'h040, 4'h0, 32'h000, 32'h180, 4, 4'h0);
    stim_q[11] = make_entry(OP_DMA_COPY, 32'h0, 4'h0, 32'h000, 32'h040, 0, 4'h0);
    stim_q[12] = make_entry(OP_SWITCH, 32'h0, 4'h0, 0, 0, 0, 4'b0101);
    stim_q[13] = make_entry(OP_SWITCH, 32'h0, 4'h0, 0, 0, 0, 4'b0000);
    stim_q[14] = make_entry(OP_HOST_READ, 32'h104, 4'h0, 0, 0, 0, 4'h0);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("gnt after reset", 32'(host_rsp_o.gnt), 32'd0);
    check_value("rvalid after reset", 32'(host_rsp_o.rvalid), 32'd0);
    check_value("interrupt after reset", 32'(dma_done_intr_o), 32'd0);
    check_value("switch ack after reset", 32'(switch_ack_no), 32'hF);
    reg_read(ext_bus_pkg::REG_STATUS, status);
    check_value("status after reset", status, 32'h0);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      apply_entry(stim_q[i]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* build.f */
rtl/ext_bus_pkg.sv
rtl/slow_memory.sv
rtl/bus_arbiter.sv
rtl/memcopy_dma.sv
rtl/powergate_ack_delay.sv
rtl/ext_subsystem.sv
tests/ext_subsystem_sva.sv
tests/tb_ext_subsystem.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the failure line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ext_subsystem \
  -f build.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
